/* replay_pkg.sv */
/*
 * Packet replay shared definitions
 * Widths, register map and the queue engine state encoding
 */
`default_nettype none

package replay_pkg;

  localparam int data_w     = 64;
  localparam int addr_w     = 10;
  localparam int count_w    = 16;
  localparam int reg_addr_w = 6;
  localparam int reg_w      = 32;

  typedef logic [data_w-1:0]     pkt_data_t;
  typedef logic [addr_w-1:0]     store_addr_t;
  typedef logic [count_w-1:0]    replay_count_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [reg_w-1:0]      reg_data_t;

  // Global registers
  localparam reg_addr_t reg_ctrl   = 6'd0;
  localparam reg_addr_t reg_status = 6'd1;

  // Per-queue block, four words per queue
  localparam reg_addr_t reg_queue_base = 6'd4;

  localparam logic [1:0] qoff_ctrl  = 2'd0;
  localparam logic [1:0] qoff_count = 2'd1;
  localparam logic [1:0] qoff_low   = 2'd2;
  localparam logic [1:0] qoff_high  = 2'd3;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    WAIT_DONE
  } queue_state_t;

endpackage

`default_nettype wire

/* replay_regs.sv */
/*
 * Replay register block
 * Simple register bus with one-cycle read latency, per-queue configuration,
 * start pulses and the read-only status word
 */
`default_nettype none

module replay_regs #(
  parameter int num_queues = 4
) (
  input  wire logic                        axi_aclk,
  input  wire logic                        reset,
  input  wire logic                        reg_wr,
  input  wire logic                        reg_rd,
  input  wire replay_pkg::reg_addr_t       reg_addr,
  input  wire replay_pkg::reg_data_t       reg_wdata,
  output replay_pkg::reg_data_t            reg_rdata,
  input  wire logic                        busy [num_queues],
  input  wire replay_pkg::store_addr_t     wr_ptr,
  output logic                             sw_reset,
  output logic                             q_enable [num_queues],
  output logic                             q_start [num_queues],
  output replay_pkg::replay_count_t        q_count [num_queues],
  output replay_pkg::store_addr_t          q_low [num_queues],
  output replay_pkg::store_addr_t          q_high [num_queues]
);

  localparam int q_words = 4 * num_queues;

  replay_pkg::reg_addr_t          q_rel;
  logic [replay_pkg::reg_addr_w-3:0] q_idx;
  logic                           in_queue_space;
  replay_pkg::reg_data_t          rd_mux;

  // Offset into the per-queue block
  assign q_rel = reg_addr - replay_pkg::reg_queue_base;
  assign q_idx = q_rel[replay_pkg::reg_addr_w-1:2];
  assign in_queue_space = (reg_addr >= replay_pkg::reg_queue_base) && (int'(q_rel) < q_words);

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      sw_reset <= 1'b0;
      for (int q = 0; q < num_queues; q++) begin
        q_enable[q] <= 1'b0;
        q_start[q]  <= 1'b0;
        q_count[q]  <= '0;
        q_low[q]    <= '0;
        q_high[q]   <= '0;
      end
    end else begin
      for (int q = 0; q < num_queues; q++) begin
        q_start[q] <= 1'b0;
      end
      if (reg_wr && reg_addr == replay_pkg::reg_ctrl) begin
        sw_reset <= reg_wdata[0];
      end
      if (reg_wr && in_queue_space) begin
        for (int q = 0; q < num_queues; q++) begin
          if (int'(q_idx) == q) begin
            case (q_rel[1:0])
              replay_pkg::qoff_ctrl: begin
                q_enable[q] <= reg_wdata[0];
                // Start is a pulse, never while software reset is held
                q_start[q]  <= reg_wdata[1] && !sw_reset;
              end
              replay_pkg::qoff_count: q_count[q] <= reg_wdata[replay_pkg::count_w-1:0];
              replay_pkg::qoff_low:   q_low[q]   <= reg_wdata[replay_pkg::addr_w-1:0];
              default:                q_high[q]  <= reg_wdata[replay_pkg::addr_w-1:0];
            endcase
          end
        end
      end
    end
  end

  // Readback mux, unmapped words are zero
  always_comb begin
    rd_mux = '0;
    if (reg_addr == replay_pkg::reg_ctrl) begin
      rd_mux[0] = sw_reset;
    end else if (reg_addr == replay_pkg::reg_status) begin
      for (int q = 0; q < num_queues; q++) begin
        rd_mux[q] = busy[q];
      end
      rd_mux[16 +: replay_pkg::addr_w] = wr_ptr;
    end else if (in_queue_space) begin
      for (int q = 0; q < num_queues; q++) begin
        if (int'(q_idx) == q) begin
          case (q_rel[1:0])
            replay_pkg::qoff_ctrl:  rd_mux[0] = q_enable[q];
            replay_pkg::qoff_count: rd_mux[replay_pkg::count_w-1:0] = q_count[q];
            replay_pkg::qoff_low:   rd_mux[replay_pkg::addr_w-1:0] = q_low[q];
            default:                rd_mux[replay_pkg::addr_w-1:0] = q_high[q];
          endcase
        end
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* pcap_store.sv */
/*
 * Packet store
 * Input stream writes data and end-of-packet at an incrementing pointer,
 * one registered read port serves the replay queues
 */
`default_nettype none

module pcap_store (
  input  wire logic                    axi_aclk,
  input  wire logic                    reset,
  input  wire logic                    sw_reset,
  input  wire logic                    s_valid,
  input  wire replay_pkg::pkt_data_t   s_data,
  input  wire logic                    s_last,
  output replay_pkg::store_addr_t      wr_ptr,
  input  wire logic                    rd_en,
  input  wire replay_pkg::store_addr_t rd_addr,
  output replay_pkg::pkt_data_t        rd_data,
  output logic                         rd_last
);

  localparam int depth = 2 ** replay_pkg::addr_w;

  replay_pkg::pkt_data_t mem_data [depth];
  logic                  mem_last [depth];
  logic                  wr_en;

  // Writes are dropped while software reset holds the pointer
  assign wr_en = s_valid && !sw_reset;

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_reset) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem_data[wr_ptr] <= s_data;
      mem_last[wr_ptr] <= s_last;
    end
  end

  // One cycle read latency
  always_ff @(posedge axi_aclk) begin
    if (rd_en) begin
      rd_data <= mem_data[rd_addr];
      rd_last <= mem_last[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* read_arbiter.sv */
/*
 * Store read arbiter
 * Round-robin grant among queue requests, tags each read with its queue and
 * routes the returned word to that queue one cycle after the store answers
 */
`default_nettype none

module read_arbiter #(
  parameter int num_queues = 4
) (
  input  wire logic                    axi_aclk,
  input  wire logic                    reset,
  input  wire logic                    rd_req [num_queues],
  input  wire replay_pkg::store_addr_t rd_addr [num_queues],
  output logic                         rd_grant [num_queues],
  output logic                         mem_rd_en,
  output replay_pkg::store_addr_t      mem_rd_addr,
  input  wire replay_pkg::pkt_data_t   mem_rd_data,
  input  wire logic                    mem_rd_last,
  output logic                         rsp_valid [num_queues],
  output replay_pkg::pkt_data_t        rsp_data [num_queues],
  output logic                         rsp_last [num_queues]
);

  localparam int tag_w = (num_queues > 1) ? $clog2(num_queues) : 1;

  logic [tag_w-1:0]      rr_ptr;
  logic [tag_w-1:0]      grant_idx;
  logic                  grant_found;
  logic [tag_w-1:0]      tag_q;
  logic                  tag_valid;
  replay_pkg::pkt_data_t rsp_data_q;
  logic                  rsp_last_q;

  // First requester at or after the pointer wins
  always_comb begin : pick
    int cand;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int i = 0; i < num_queues; i++) begin
      cand = int'(rr_ptr) + i;
      if (cand >= num_queues) begin
        cand = cand - num_queues;
      end
      if (!grant_found && rd_req[cand]) begin
        grant_found = 1'b1;
        grant_idx   = tag_w'(cand);
      end
    end
  end

  always_comb begin
    for (int q = 0; q < num_queues; q++) begin
      rd_grant[q] = grant_found && (int'(grant_idx) == q);
    end
  end

  assign mem_rd_en   = grant_found;
  assign mem_rd_addr = rd_addr[grant_idx];

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      rr_ptr <= '0;
    end else if (grant_found) begin
      if (int'(grant_idx) == num_queues - 1) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= grant_idx + 1'b1;
      end
    end
  end

  // Tag travels alongside the store read
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      tag_valid <= 1'b0;
      for (int q = 0; q < num_queues; q++) begin
        rsp_valid[q] <= 1'b0;
      end
    end else begin
      tag_valid <= mem_rd_en;
      for (int q = 0; q < num_queues; q++) begin
        rsp_valid[q] <= tag_valid && (int'(tag_q) == q);
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (mem_rd_en) begin
      tag_q <= grant_idx;
    end
    if (tag_valid) begin
      rsp_data_q <= mem_rd_data;
      rsp_last_q <= mem_rd_last;
    end
  end

  // Payload is shared, only the valid is steered
  always_comb begin
    for (int q = 0; q < num_queues; q++) begin
      rsp_data[q] = rsp_data_q;
      rsp_last[q] = rsp_last_q;
    end
  end

endmodule

`default_nettype wire

/* replay_queue_engine.sv */
/*
 * Replay queue engine
 * Walks the configured address range once per pass, issuing one store read
 * per grant, then waits for its outstanding words to leave the port
 */
`default_nettype none

module replay_queue_engine (
  input  wire logic                      axi_aclk,
  input  wire logic                      reset,
  input  wire logic                      sw_reset,
  input  wire logic                      enable,
  input  wire logic                      start,
  input  wire replay_pkg::replay_count_t count,
  input  wire replay_pkg::store_addr_t   low,
  input  wire replay_pkg::store_addr_t   high,
  input  wire logic                      can_issue,
  input  wire logic                      rd_grant,
  input  wire logic                      out_done,
  output logic                           rd_req,
  output replay_pkg::store_addr_t        rd_addr,
  output logic                           busy
);

  replay_pkg::queue_state_t  state;
  replay_pkg::store_addr_t   cur_addr;
  replay_pkg::replay_count_t passes;
  logic                      range_ok;

  // Empty runs never leave idle
  assign range_ok = (count != '0) && (high >= low);

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_reset) begin
      state  <= replay_pkg::IDLE;
      passes <= '0;
    end else begin
      case (state)
        replay_pkg::IDLE: begin
          if (start && enable && range_ok) begin
            state    <= replay_pkg::RUN;
            cur_addr <= low;
            passes   <= count;
          end
        end
        replay_pkg::RUN: begin
          if (!enable) begin
            // Stop issuing, let in-flight words drain
            state <= replay_pkg::WAIT_DONE;
          end else if (rd_grant) begin
            if (cur_addr == high) begin
              cur_addr <= low;
              passes   <= passes - 1'b1;
              if (passes == replay_pkg::replay_count_t'(1)) begin
                state <= replay_pkg::WAIT_DONE;
              end
            end else begin
              cur_addr <= cur_addr + 1'b1;
            end
          end
        end
        replay_pkg::WAIT_DONE: begin
          if (out_done) begin
            state <= replay_pkg::IDLE;
          end
        end
        default: state <= replay_pkg::IDLE;
      endcase
    end
  end

  assign rd_req  = (state == replay_pkg::RUN) && enable && can_issue;
  assign rd_addr = cur_addr;
  assign busy    = (state != replay_pkg::IDLE);

endmodule

`default_nettype wire

/* tx_credit_port.sv */
/*
 * Credit-based output port
 * Credits are taken at grant time and returned by the sink; the port also
 * tracks words in flight and registers the outgoing word
 */
`default_nettype none

module tx_credit_port #(
  parameter int init_credits = 4
) (
  input  wire logic                  axi_aclk,
  input  wire logic                  reset,
  input  wire logic                  sw_reset,
  input  wire logic                  rd_grant,
  input  wire logic                  m_credit,
  input  wire logic                  rsp_valid,
  input  wire replay_pkg::pkt_data_t rsp_data,
  input  wire logic                  rsp_last,
  output logic                       can_issue,
  output logic                       out_done,
  output logic                       m_valid,
  output replay_pkg::pkt_data_t      m_data,
  output logic                       m_last
);

  localparam int credit_w = $clog2(init_credits + 1) + 1;
  // Pipeline between grant and output holds at most three words
  localparam int flight_w = $clog2(init_credits + 4);

  logic [credit_w-1:0] credits;
  logic [flight_w-1:0] inflight;

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_reset) begin
      credits  <= credit_w'(init_credits);
      inflight <= '0;
      m_valid  <= 1'b0;
    end else begin
      case ({rd_grant, m_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
      case ({rd_grant, rsp_valid})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
      m_valid <= rsp_valid;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (rsp_valid) begin
      m_data <= rsp_data;
      m_last <= rsp_last;
    end
  end

  assign can_issue = (credits != '0);
  // Done once the last word has also left the output register
  assign out_done  = (inflight == '0) && !m_valid;

endmodule

`default_nettype wire

/* pcap_replay_top.sv */
/*
 * Packet capture replay engine
 * Input stream fills the packet store, per-queue engines replay address
 * ranges through a shared read arbiter onto credit-controlled outputs
 */
`default_nettype none

module pcap_replay_top #(
  parameter int num_queues   = 4,
  parameter int init_credits = 4
) (
  input  wire logic                  axi_aclk,
  input  wire logic                  reset,
  input  wire logic                  s_valid,
  input  wire replay_pkg::pkt_data_t s_data,
  input  wire logic                  s_last,
  input  wire logic                  reg_wr,
  input  wire logic                  reg_rd,
  input  wire replay_pkg::reg_addr_t reg_addr,
  input  wire replay_pkg::reg_data_t reg_wdata,
  input  wire logic                  m_credit [num_queues],
  output replay_pkg::reg_data_t      reg_rdata,
  output logic                       m_valid [num_queues],
  output replay_pkg::pkt_data_t      m_data [num_queues],
  output logic                       m_last [num_queues]
);

  logic                      sw_reset;
  replay_pkg::store_addr_t   wr_ptr;
  logic                      busy [num_queues];
  logic                      q_enable [num_queues];
  logic                      q_start [num_queues];
  replay_pkg::replay_count_t q_count [num_queues];
  replay_pkg::store_addr_t   q_low [num_queues];
  replay_pkg::store_addr_t   q_high [num_queues];

  logic                      rd_req [num_queues];
  replay_pkg::store_addr_t   rd_addr [num_queues];
  logic                      rd_grant [num_queues];
  logic                      can_issue [num_queues];
  logic                      out_done [num_queues];
  logic                      rsp_valid [num_queues];
  replay_pkg::pkt_data_t     rsp_data [num_queues];
  logic                      rsp_last [num_queues];

  logic                      mem_rd_en;
  replay_pkg::store_addr_t   mem_rd_addr;
  replay_pkg::pkt_data_t     mem_rd_data;
  logic                      mem_rd_last;

  replay_regs #(
    .num_queues (num_queues)
  ) replay_regs_inst (
    .axi_aclk  (axi_aclk),
    .reset     (reset),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .busy      (busy),
    .wr_ptr    (wr_ptr),
    .sw_reset  (sw_reset),
    .q_enable  (q_enable),
    .q_start   (q_start),
    .q_count   (q_count),
    .q_low     (q_low),
    .q_high    (q_high)
  );

  pcap_store pcap_store_inst (
    .axi_aclk (axi_aclk),
    .reset    (reset),
    .sw_reset (sw_reset),
    .s_valid  (s_valid),
    .s_data   (s_data),
    .s_last   (s_last),
    .wr_ptr   (wr_ptr),
    .rd_en    (mem_rd_en),
    .rd_addr  (mem_rd_addr),
    .rd_data  (mem_rd_data),
    .rd_last  (mem_rd_last)
  );

  read_arbiter #(
    .num_queues (num_queues)
  ) read_arbiter_inst (
    .axi_aclk    (axi_aclk),
    .reset       (reset),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_grant    (rd_grant),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data),
    .mem_rd_last (mem_rd_last),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data),
    .rsp_last    (rsp_last)
  );

  for (genvar q = 0; q < num_queues; q++) begin : g_engine
    replay_queue_engine replay_queue_engine_inst (
      .axi_aclk  (axi_aclk),
      .reset     (reset),
      .sw_reset  (sw_reset),
      .enable    (q_enable[q]),
      .start     (q_start[q]),
      .count     (q_count[q]),
      .low       (q_low[q]),
      .high      (q_high[q]),
      .can_issue (can_issue[q]),
      .rd_grant  (rd_grant[q]),
      .out_done  (out_done[q]),
      .rd_req    (rd_req[q]),
      .rd_addr   (rd_addr[q]),
      .busy      (busy[q])
    );
  end

  for (genvar q = 0; q < num_queues; q++) begin : g_port
    tx_credit_port #(
      .init_credits (init_credits)
    ) tx_credit_port_inst (
      .axi_aclk  (axi_aclk),
      .reset     (reset),
      .sw_reset  (sw_reset),
      .rd_grant  (rd_grant[q]),
      .m_credit  (m_credit[q]),
      .rsp_valid (rsp_valid[q]),
      .rsp_data  (rsp_data[q]),
      .rsp_last  (rsp_last[q]),
      .can_issue (can_issue[q]),
      .out_done  (out_done[q]),
      .m_valid   (m_valid[q]),
      .m_data    (m_data[q]),
      .m_last    (m_last[q])
    );
  end

endmodule

`default_nettype wire

/* pcap_replay_chk.sv */
/*
 * Credit port assertions
 * Bound to every output port, checks the credit bound, grant legality
 * and a known output valid
 */
`default_nettype none

module pcap_replay_chk #(
  parameter int init_credits = 4,
  parameter int credit_w     = 4
) (
  input wire logic                axi_aclk,
  input wire logic                reset,
  input wire logic                rd_grant,
  input wire logic                can_issue,
  input wire logic                m_valid,
  input wire logic [credit_w-1:0] credits
);

  // Read by the testbench summary
  int assert_fails = 0;

  credits_bounded: assert property (
    @(posedge axi_aclk) disable iff (reset) credits <= credit_w'(init_credits)
  ) else begin
    $error("credit count %0d above the initial %0d", credits, init_credits);
    assert_fails++;
  end

  grant_needs_credit: assert property (
    @(posedge axi_aclk) disable iff (reset) !(rd_grant && !can_issue)
  ) else begin
    $error("read granted to a port without credit");
    assert_fails++;
  end

  valid_known: assert property (
    @(posedge axi_aclk) disable iff (reset) !$isunknown(m_valid)
  ) else begin
    $error("m_valid is unknown");
    assert_fails++;
  end

endmodule

bind tx_credit_port pcap_replay_chk #(
  .init_credits (init_credits),
  .credit_w     (credit_w)
) pcap_replay_chk_inst (
  .axi_aclk  (axi_aclk),
  .reset     (reset),
  .rd_grant  (rd_grant),
  .can_issue (can_issue),
  .m_valid   (m_valid),
  .credits   (credits)
);

`default_nettype wire

/* tb_pcap_replay.sv */
/*
 * Testbench for the packet capture replay engine
 * Directed tests for the register map, single and multi-pass replay,
 * credit back-pressure between two queues and software reset
 */
`default_nettype none

module tb_pcap_replay;

  localparam int num_queues  = 4;
  localparam int init_credits = 4;
  localparam int clk_period  = 20;
  localparam int drive_delay = 2;
  localparam int cap_depth   = 64;
  // Cycle budget per test plus a margin
  localparam int test_cycles = 100 + 300 + 300 + 600 + 400;
  localparam int watchdog_cycles = test_cycles + 1000;

  logic                  axi_aclk;
  logic                  reset;
  logic                  s_valid;
  replay_pkg::pkt_data_t s_data;
  logic                  s_last;
  logic                  reg_wr;
  logic                  reg_rd;
  replay_pkg::reg_addr_t reg_addr;
  replay_pkg::reg_data_t reg_wdata;
  logic                  m_credit [num_queues];
  replay_pkg::reg_data_t reg_rdata;
  logic                  m_valid [num_queues];
  replay_pkg::pkt_data_t m_data [num_queues];
  logic                  m_last [num_queues];

  // Expected store contents
  replay_pkg::pkt_data_t exp_data [cap_depth];
  logic                  exp_last [cap_depth];
  int                    model_ptr;

  replay_pkg::pkt_data_t got_data [num_queues][cap_depth];
  logic                  got_last [num_queues][cap_depth];
  int                    got_cnt [num_queues];
  int                    owed [num_queues];
  logic                  credit_hold [num_queues];
  logic [15:0]           lfsr_state;
  int                    value_errors;
  int                    other_errors;
  int                    assert_errors;

  pcap_replay_top #(
    .num_queues   (num_queues),
    .init_credits (init_credits)
  ) pcap_replay_top_inst (
    .axi_aclk  (axi_aclk),
    .reset     (reset),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_last    (s_last),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .m_credit  (m_credit),
    .reg_rdata (reg_rdata),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_last    (m_last)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #(clk_period / 2) axi_aclk = ~axi_aclk;
  end

  // Sink side sampled mid-cycle
  always @(negedge axi_aclk) begin
    for (int q = 0; q < num_queues; q++) begin
      if (!reset && m_valid[q] === 1'b1) begin
        if (got_cnt[q] < cap_depth) begin
          got_data[q][got_cnt[q]] = m_data[q];
          got_last[q][got_cnt[q]] = m_last[q];
        end
        got_cnt[q] = got_cnt[q] + 1;
        owed[q] = owed[q] + 1;
      end
    end
  end

  // One credit back per received word and at most one per cycle
  always @(posedge axi_aclk) begin
    #drive_delay;
    for (int q = 0; q < num_queues; q++) begin
      if (!credit_hold[q] && owed[q] > 0) begin
        m_credit[q] = 1'b1;
        owed[q] = owed[q] - 1;
      end else begin
        m_credit[q] = 1'b0;
      end
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("Errors found");
    $finish;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hb400;
    end
    return n;
  endfunction

  task automatic random_word(output replay_pkg::pkt_data_t w);
    for (int b = 0; b < replay_pkg::data_w; b++) begin
      w[b] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_data(input string name, input replay_pkg::pkt_data_t got,
                            input replay_pkg::pkt_data_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_reg(input string name, input replay_pkg::reg_data_t got,
                           input replay_pkg::reg_data_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  function automatic replay_pkg::reg_addr_t queue_reg(input int q, input logic [1:0] off);
    return replay_pkg::reg_addr_t'(int'(replay_pkg::reg_queue_base) + 4 * q + int'(off));
  endfunction

  task automatic reg_write(input replay_pkg::reg_addr_t addr,
                           input replay_pkg::reg_data_t data);
    @(posedge axi_aclk);
    #drive_delay;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge axi_aclk);
    #drive_delay;
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input replay_pkg::reg_addr_t addr,
                          output replay_pkg::reg_data_t data);
    @(posedge axi_aclk);
    #drive_delay;
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(posedge axi_aclk);
    #drive_delay;
    reg_rd = 1'b0;
    data   = reg_rdata;
  endtask

  task automatic setup_queue(input int q, input int low, input int high, input int count,
                             input logic start);
    reg_write(queue_reg(q, replay_pkg::qoff_count), count);
    reg_write(queue_reg(q, replay_pkg::qoff_low), low);
    reg_write(queue_reg(q, replay_pkg::qoff_high), high);
    reg_write(queue_reg(q, replay_pkg::qoff_ctrl), {30'd0, start, 1'b1});
  endtask

  // End-of-packet on every fourth word
  task automatic load_packets(input int n);
    replay_pkg::pkt_data_t w;
    for (int i = 0; i < n; i++) begin
      random_word(w);
      @(posedge axi_aclk);
      #drive_delay;
      s_valid = 1'b1;
      s_data  = w;
      s_last  = (i % 4 == 3);
      exp_data[model_ptr] = w;
      exp_last[model_ptr] = (i % 4 == 3);
      model_ptr++;
    end
    @(posedge axi_aclk);
    #drive_delay;
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic clear_capture();
    for (int q = 0; q < num_queues; q++) begin
      got_cnt[q] = 0;
    end
  endtask

  task automatic wait_words(input int q, input int n);
    int cycles;
    cycles = 0;
    while (got_cnt[q] < n && cycles < 500) begin
      @(posedge axi_aclk);
      cycles++;
    end
    if (got_cnt[q] < n) begin
      $display("Queue %0d sent only %0d of %0d words in time", q, got_cnt[q], n);
      other_errors++;
    end
  endtask

  task automatic wait_idle(input logic [num_queues-1:0] mask);
    replay_pkg::reg_data_t rd;
    int polls;
    polls = 0;
    rd = '1;
    while ((rd[num_queues-1:0] & mask) != '0 && polls < 50) begin
      reg_read(replay_pkg::reg_status, rd);
      polls++;
    end
    if ((rd[num_queues-1:0] & mask) != '0) begin
      $display("Busy flags %b still set after %0d status reads", rd[num_queues-1:0], polls);
      other_errors++;
    end
  endtask

  task automatic check_replay(input int q, input int low, input int high, input int passes);
    int len;
    int addr;
    len = high - low + 1;
    check_count($sformatf("queue %0d word count", q), got_cnt[q], len * passes);
    for (int i = 0; i < got_cnt[q] && i < cap_depth; i++) begin
      addr = low + (i % len);
      check_data($sformatf("m_data[%0d] word %0d", q, i), got_data[q][i], exp_data[addr]);
      check_last($sformatf("m_last[%0d] word %0d", q, i), got_last[q][i], exp_last[addr]);
    end
  endtask

  task automatic test_reg_defaults();
    replay_pkg::reg_data_t rd;
    reg_read(replay_pkg::reg_ctrl, rd);
    check_reg("ctrl", rd, '0);
    reg_read(replay_pkg::reg_status, rd);
    check_reg("status", rd, '0);
    for (int a = 0; a < 4 * num_queues; a++) begin
      reg_read(replay_pkg::reg_queue_base + a, rd);
      check_reg($sformatf("queue word %0d", a), rd, '0);
    end
    reg_read(6'd2, rd);
    check_reg("unmapped 2", rd, '0);
    reg_read(6'd63, rd);
    check_reg("unmapped 63", rd, '0);
    // Count still zero so the start bit cannot launch a run
    reg_write(queue_reg(2, replay_pkg::qoff_ctrl), 32'h3);
    reg_write(queue_reg(2, replay_pkg::qoff_count), 32'h1234);
    reg_write(queue_reg(2, replay_pkg::qoff_low), 32'h155);
    reg_write(queue_reg(2, replay_pkg::qoff_high), 32'h2aa);
    reg_read(queue_reg(2, replay_pkg::qoff_ctrl), rd);
    check_reg("queue 2 ctrl", rd, 32'h1);
    reg_read(queue_reg(2, replay_pkg::qoff_count), rd);
    check_reg("queue 2 count", rd, 32'h1234);
    reg_read(queue_reg(2, replay_pkg::qoff_low), rd);
    check_reg("queue 2 low", rd, 32'h155);
    reg_read(queue_reg(2, replay_pkg::qoff_high), rd);
    check_reg("queue 2 high", rd, 32'h2aa);
    reg_write(queue_reg(2, replay_pkg::qoff_ctrl), 32'h0);
  endtask

  task automatic test_single_replay();
    replay_pkg::reg_data_t rd;
    clear_capture();
    load_packets(12);
    reg_read(replay_pkg::reg_status, rd);
    check_reg("status after load", rd, 32'd12 << 16);
    setup_queue(0, 0, 11, 1, 1'b1);
    wait_words(0, 12);
    wait_idle(4'b0001);
    check_replay(0, 0, 11, 1);
  endtask

  task automatic test_multi_pass();
    replay_pkg::reg_data_t rd;
    clear_capture();
    setup_queue(0, 4, 7, 3, 1'b1);
    wait_words(0, 12);
    // Status sampled in the fourth cycle after the last m_valid
    repeat (2) @(posedge axi_aclk);
    reg_read(replay_pkg::reg_status, rd);
    check_reg("status after three passes", rd, 32'd12 << 16);
    check_replay(0, 4, 7, 3);
  endtask

  task automatic test_credit_stall();
    replay_pkg::reg_data_t rd;
    clear_capture();
    credit_hold[1] = 1'b1;
    setup_queue(1, 4, 7, 2, 1'b1);
    setup_queue(0, 0, 11, 1, 1'b1);
    wait_words(0, 12);
    repeat (10) @(posedge axi_aclk);
    check_count("queue 1 words without credit", got_cnt[1], init_credits);
    reg_read(replay_pkg::reg_status, rd);
    check_reg("status with queue 1 stalled", rd, (32'd12 << 16) | 32'h2);
    check_replay(0, 0, 11, 1);
    credit_hold[1] = 1'b0;
    wait_words(1, 8);
    wait_idle(4'b0011);
    check_replay(1, 4, 7, 2);
  endtask

  task automatic test_sw_reset();
    replay_pkg::reg_data_t rd;
    clear_capture();
    setup_queue(0, 0, 11, 100, 1'b1);
    wait_words(0, 5);
    reg_write(replay_pkg::reg_ctrl, 32'h1);
    // Port credits restart so pending returns are dropped
    repeat (3) @(negedge axi_aclk);
    for (int q = 0; q < num_queues; q++) begin
      owed[q] = 0;
    end
    model_ptr = 0;
    reg_read(replay_pkg::reg_status, rd);
    check_reg("status in software reset", rd, '0);
    reg_read(replay_pkg::reg_ctrl, rd);
    check_reg("ctrl in software reset", rd, 32'h1);
    reg_write(replay_pkg::reg_ctrl, 32'h0);
    reg_read(queue_reg(0, replay_pkg::qoff_ctrl), rd);
    check_reg("queue 0 ctrl kept", rd, 32'h1);
    reg_read(queue_reg(0, replay_pkg::qoff_count), rd);
    check_reg("queue 0 count kept", rd, 32'd100);
    reg_read(queue_reg(0, replay_pkg::qoff_high), rd);
    check_reg("queue 0 high kept", rd, 32'd11);
    // Start pulse with enable clear
    clear_capture();
    reg_write(queue_reg(0, replay_pkg::qoff_ctrl), 32'h2);
    reg_read(replay_pkg::reg_status, rd);
    check_reg("status without enable", rd, '0);
    repeat (20) @(posedge axi_aclk);
    check_count("queue 0 words without enable", got_cnt[0], 0);
  endtask

  function automatic int assertion_failures();
    return pcap_replay_top_inst.g_port[0].tx_credit_port_inst.pcap_replay_chk_inst.assert_fails
         + pcap_replay_top_inst.g_port[1].tx_credit_port_inst.pcap_replay_chk_inst.assert_fails
         + pcap_replay_top_inst.g_port[2].tx_credit_port_inst.pcap_replay_chk_inst.assert_fails
         + pcap_replay_top_inst.g_port[3].tx_credit_port_inst.pcap_replay_chk_inst.assert_fails;
  endfunction

  initial begin
    reset        = 1'b1;
    s_valid      = 1'b0;
    s_data       = '0;
    s_last       = 1'b0;
    reg_wr       = 1'b0;
    reg_rd       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    lfsr_state   = 16'd16;
    model_ptr    = 0;
    value_errors = 0;
    other_errors = 0;
    for (int q = 0; q < num_queues; q++) begin
      m_credit[q]    = 1'b0;
      got_cnt[q]     = 0;
      owed[q]        = 0;
      credit_hold[q] = 1'b0;
    end
    repeat (4) @(posedge axi_aclk);
    #drive_delay;
    reset = 1'b0;

    test_reg_defaults();
    test_single_replay();
    test_multi_pass();
    test_credit_stall();
    test_sw_reset();

    assert_errors = assertion_failures();
    $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
             value_errors, other_errors, assert_errors);
    if (value_errors + other_errors + assert_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
replay_pkg.sv
replay_regs.sv
pcap_store.sv
read_arbiter.sv
replay_queue_engine.sv
tx_credit_port.sv
pcap_replay_top.sv
pcap_replay_chk.sv
tb_pcap_replay.sv
